// ==== Makefile ====
SIM        = verilator
TOP        = tb_keypad_word
FILELIST   = verilog.f
SIM_FLAGS  = --binary --timing -Wno-fatal --top-module $(TOP)
LINT_FLAGS = --lint-only --timing -Wall -Wno-fatal --top-module $(TOP)
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/keypad_params.svh ====
`ifndef KEYPAD_PARAMS_SVH
`define KEYPAD_PARAMS_SVH

// Clock cycles each column stays driven before the scan moves on.
// The rows pass a two-flop synchronizer and are sampled at the end of
// each slot, so this must be at least 3.
// A full sweep of four columns takes 4 * KEYPAD_SCAN_DIV cycles
`define KEYPAD_SCAN_DIV 8

// Full sweeps that a new key code must stay the same before it is taken.
// Release is filtered the same way: the all-zero sweep code has to
// repeat this many sweeps before cur_key goes back to zero
`define KEYPAD_DEBOUNCE 3

// Most letters one word can hold
// Letters submitted after that are dropped until the word is sent
`define WORD_MAX_LEN 8

`endif

// ==== common/keypad_pkg.sv ====
package keypad_pkg;

  // Bits 7:4 one-hot row (bit 7 is row 0)
  // Bits 3:0 one-hot column (bit 3 is column 0)
  // All zero means no key
  typedef logic [7:0] key_code_t;

  // Control keys, bottom row and column 3
  localparam key_code_t key_submit_letter = 8'b0001_1000; // R3C0, '*'
  localparam key_code_t key_clear         = 8'b0001_0100; // R3C1, '0'
  localparam key_code_t key_submit_word   = 8'b0001_0010; // R3C2, '#'
  localparam key_code_t key_game_end      = 8'b0010_0001; // R2C3, 'C'

  // Letter keys with four letters
  localparam key_code_t key_7 = 8'b0010_1000; // R2C0, PQRS
  localparam key_code_t key_9 = 8'b0010_0010; // R2C2, WXYZ

  // Keys the scanner reports but the letter FSM ignores
  localparam key_code_t key_1 = 8'b1000_1000; // R0C0
  localparam key_code_t key_a = 8'b1000_0001; // R0C3
  localparam key_code_t key_b = 8'b0100_0001; // R1C3
  localparam key_code_t key_d = 8'b0001_0001; // R3C3

  // Multi-tap state
  // S0 to S3 double as the tap offset added to the base letter
  typedef enum logic [2:0] {
    INIT = 3'd0, // Nothing being built
    S0   = 3'd1, // First letter of the key
    S1   = 3'd2,
    S2   = 3'd3,
    S3   = 3'd4, // Only reached on keys 7 and 9
    DONE = 3'd5  // Letter submitted, ready follows
  } tap_state_t;

  // ASCII underscore while no letter is in progress
  localparam logic [7:0] blank_char = 8'h5F;

endpackage

// ==== common/word_pkg.sv ====
`include "keypad_params.svh"

package word_pkg;

  // One ASCII character
  typedef logic [7:0] letter_t;

  // Index 0 holds the first letter typed
  typedef letter_t [`WORD_MAX_LEN-1:0] word_t;

  // Wide enough for a full word, not just the last index
  localparam int unsigned word_len_w = $clog2(`WORD_MAX_LEN + 1);

  typedef logic [word_len_w-1:0] word_len_t;

endpackage

// ==== keypad/keypad_fsm.sv ====
module keypad_fsm (
  input  logic                  clk,
  input  logic                  nRst,
  input  logic                  strobe,       // From scanner, one cycle
  input  keypad_pkg::key_code_t cur_key,      // Held while pressed
  output logic                  ready,        // Letter submitted
  output logic                  game_end,     // C key pressed
  output word_pkg::letter_t     data,         // Letter being built
  output logic                  toggle_state  // Word submit level
);
  keypad_pkg::tap_state_t state, next_state;
  keypad_pkg::key_code_t  prev_key;        // Last key after unlock
  word_pkg::letter_t      next_data;
  logic                   unlocked, next_unlocked;
  logic                   ignored_key;
  logic                   letter_key;
  logic                   four_letters;

  // Base letter of a key plus the tap offset
  function automatic word_pkg::letter_t tap_letter(
    input keypad_pkg::key_code_t  key,
    input keypad_pkg::tap_state_t tap
  );
    word_pkg::letter_t base;
    case (key)
      8'b1000_0100: base = "A"; // 2
      8'b1000_0010: base = "D"; // 3
      8'b0100_1000: base = "G"; // 4
      8'b0100_0100: base = "J"; // 5
      8'b0100_0010: base = "M"; // 6
      8'b0010_1000: base = "P"; // 7
      8'b0010_0100: base = "T"; // 8
      8'b0010_0010: base = "W"; // 9
      default:      base = 8'd0; // Not a letter key
    endcase
    if ((tap >= keypad_pkg::S0) && (tap <= keypad_pkg::S3))
      base = base + 8'(tap - keypad_pkg::S0);
    return base;
  endfunction

  // Step to the next letter of the same key
  function automatic keypad_pkg::tap_state_t next_tap(
    input keypad_pkg::tap_state_t cur,
    input logic                   four
  );
    case (cur)
      keypad_pkg::INIT: next_tap = keypad_pkg::S0;
      keypad_pkg::S0:   next_tap = keypad_pkg::S1;
      keypad_pkg::S1:   next_tap = keypad_pkg::S2;
      keypad_pkg::S2:   next_tap = four ? keypad_pkg::S3 : keypad_pkg::S0;
      default:          next_tap = keypad_pkg::S0; // Wrap after S3
    endcase
  endfunction

  assign ignored_key  = (cur_key == keypad_pkg::key_1) || (cur_key == keypad_pkg::key_a) ||
                        (cur_key == keypad_pkg::key_b) || (cur_key == keypad_pkg::key_d);
  assign letter_key   = (tap_letter(cur_key, keypad_pkg::S0) != 8'd0);
  assign four_letters = (cur_key == keypad_pkg::key_7) || (cur_key == keypad_pkg::key_9);

  always_ff @(posedge clk, negedge nRst) begin
    if (~nRst) begin
      state    <= keypad_pkg::INIT;
      ready    <= 1'b0;
      data     <= keypad_pkg::blank_char;
      unlocked <= 1'b0;
      prev_key <= '0;
    end else begin
      state    <= next_state;
      ready    <= (state == keypad_pkg::DONE); // One cycle after DONE
      data     <= next_data;
      unlocked <= next_unlocked;
      // Remember the key one cycle after the press was acted on
      if (unlocked && (cur_key != '0))
        prev_key <= cur_key;
    end
  end

  always_comb begin
    next_state    = state;
    next_data     = data;
    next_unlocked = unlocked;
    game_end      = 1'b0;
    toggle_state  = 1'b0;

    if (state == keypad_pkg::DONE)
      next_state = keypad_pkg::INIT;

    // Idle shows blank, except right after a word or game end
    if ((state == keypad_pkg::INIT) && (prev_key != keypad_pkg::key_submit_word) &&
        (prev_key != keypad_pkg::key_game_end))
      next_data = keypad_pkg::blank_char;

    // Letter submit, data already holds the letter
    if ((cur_key == keypad_pkg::key_submit_letter) && (state != keypad_pkg::INIT) &&
        (state != keypad_pkg::DONE)) begin
      next_state    = keypad_pkg::DONE;
      next_unlocked = 1'b1;
    end

    // Word submit, level for as long as # is held
    if (cur_key == keypad_pkg::key_submit_word) begin
      next_state    = keypad_pkg::INIT;
      next_data     = 8'd0;
      toggle_state  = 1'b1;
      next_unlocked = 1'b1;
    end

    if (strobe && (cur_key != '0)) begin
      if (ignored_key) begin
        next_state = state; // No effect
      end else if ((cur_key == keypad_pkg::key_clear) ||
                   (cur_key == keypad_pkg::key_game_end)) begin
        next_state    = keypad_pkg::INIT;
        next_data     = keypad_pkg::blank_char;
        next_unlocked = 1'b1;
        game_end      = (cur_key == keypad_pkg::key_game_end);
      end else if (letter_key) begin
        // Same key steps the offset, a new key starts over
        if (prev_key == cur_key)
          next_state = next_tap(state, four_letters);
        else
          next_state = keypad_pkg::S0;
        next_unlocked = 1'b1;
        next_data     = tap_letter(cur_key, next_state);
      end
    end else begin
      next_unlocked = 1'b0;
    end
  end

endmodule

// ==== keypad/keypad_scan.sv ====
`include "keypad_params.svh"

module keypad_scan (
  input  logic                  clk,
  input  logic                  nRst,
  input  logic [3:0]            rows,    // Active high, not synchronous
  output logic [3:0]            cols,    // One-hot, bit 3 is column 0
  output keypad_pkg::key_code_t cur_key, // Debounced code
  output logic                  strobe   // First cycle of a press
);
  localparam int unsigned div_w = $clog2(`KEYPAD_SCAN_DIV);
  localparam int unsigned deb_w = $clog2(`KEYPAD_DEBOUNCE + 1);
  localparam logic [div_w-1:0] div_last = div_w'(`KEYPAD_SCAN_DIV - 1);
  localparam logic [deb_w-1:0] deb_full = deb_w'(`KEYPAD_DEBOUNCE);

  logic [div_w-1:0]      div_cnt;
  logic [3:0]            rows_meta, rows_sync;
  keypad_pkg::key_code_t sweep_code, sweep_next, last_code;
  logic [deb_w-1:0]      stable_cnt, stable_next;
  logic [3:0]            row_hit;
  logic                  slot_end, sweep_end;

  // Keep only the lowest numbered row when several are pressed
  function automatic logic [3:0] first_row(input logic [3:0] r);
    casez (r)
      4'b1???: first_row = 4'b1000;
      4'b01??: first_row = 4'b0100;
      4'b001?: first_row = 4'b0010;
      4'b0001: first_row = 4'b0001;
      default: first_row = 4'b0000;
    endcase
  endfunction

  assign slot_end  = (div_cnt == div_last);
  assign sweep_end = slot_end & cols[0]; // Last column done
  assign row_hit   = first_row(rows_sync);

  always_comb begin
    sweep_next = sweep_code;
    if ((sweep_code == '0) && (row_hit != 4'b0000)) // First key of the sweep wins
      sweep_next = {row_hit, cols};

    // Count sweeps with an unchanged code, saturating
    if (sweep_next != last_code)
      stable_next = deb_w'(1);
    else if (stable_cnt == deb_full)
      stable_next = stable_cnt;
    else
      stable_next = stable_cnt + deb_w'(1);
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (~nRst) begin
      div_cnt    <= '0;
      cols       <= 4'b1000; // Column 0 first
      rows_meta  <= '0;
      rows_sync  <= '0;
      sweep_code <= '0;
      last_code  <= '0;
      stable_cnt <= '0;
      cur_key    <= '0;
      strobe     <= 1'b0;
    end else begin
      rows_meta <= rows;
      rows_sync <= rows_meta;
      strobe    <= 1'b0;

      if (slot_end) begin
        div_cnt    <= '0;
        cols       <= {cols[0], cols[3:1]}; // Next column
        sweep_code <= sweep_next;
      end else begin
        div_cnt <= div_cnt + div_w'(1);
      end

      if (sweep_end) begin
        sweep_code <= '0; // Fresh sweep
        last_code  <= sweep_next;
        stable_cnt <= stable_next;
        if (stable_next == deb_full) begin
          cur_key <= sweep_next;
          // Only a press out of idle counts as a new key
          strobe  <= (cur_key == '0) && (sweep_next != '0);
        end
      end
    end
  end

endmodule

// ==== rtl/keypad_word_top.sv ====
module keypad_word_top (
  input  logic                clk,
  input  logic                nRst,
  input  logic [3:0]          rows,
  output logic [3:0]          cols,
  output word_pkg::letter_t   letter,
  output logic                letter_ready,
  output word_pkg::word_t     word,
  output word_pkg::word_len_t word_len,
  output logic                word_valid,
  output logic                game_over
);
  keypad_pkg::key_code_t cur_key;
  logic                  strobe;
  logic                  toggle_state;
  logic                  game_end;

  // Matrix scan and debounce
  keypad_scan u_scan (
    .clk     (clk),
    .nRst    (nRst),
    .rows    (rows),
    .cols    (cols),
    .cur_key (cur_key),
    .strobe  (strobe)
  );

  // Multi-tap letters
  keypad_fsm u_fsm (
    .clk          (clk),
    .nRst         (nRst),
    .strobe       (strobe),
    .cur_key      (cur_key),
    .ready        (letter_ready),
    .game_end     (game_end),
    .data         (letter),
    .toggle_state (toggle_state)
  );

  // Letters into words
  word_buffer u_buffer (
    .clk          (clk),
    .nRst         (nRst),
    .ready        (letter_ready),
    .data         (letter),
    .toggle_state (toggle_state),
    .game_end     (game_end),
    .word         (word),
    .word_len     (word_len),
    .word_valid   (word_valid),
    .game_over    (game_over)
  );

endmodule

// ==== rtl/word_buffer.sv ====
`include "keypad_params.svh"

module word_buffer (
  input  logic                clk,
  input  logic                nRst,
  input  logic                ready,        // Letter on data
  input  word_pkg::letter_t   data,
  input  logic                toggle_state, // Word submit level
  input  logic                game_end,
  output word_pkg::word_t     word,
  output word_pkg::word_len_t word_len,
  output logic                word_valid,   // One cycle per word
  output logic                game_over
);
  localparam word_pkg::word_len_t max_len = word_pkg::word_len_t'(`WORD_MAX_LEN);

  word_pkg::word_t     letters;  // Word being filled
  word_pkg::word_len_t fill_len;
  logic                toggle_d;
  logic                submit;
  logic                append;

  assign submit = toggle_state & ~toggle_d; // First cycle of # only
  assign append = ready & (fill_len < max_len); // Extra letters dropped

  // Letter storage and published word
  always_ff @(posedge clk) begin
    if (append && !submit)
      letters[fill_len] <= data;
    if (submit)
      word <= letters;
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (~nRst) begin
      fill_len   <= '0;
      toggle_d   <= 1'b0;
      word_len   <= '0;
      word_valid <= 1'b0;
      game_over  <= 1'b0;
    end else begin
      toggle_d   <= toggle_state;
      word_valid <= submit;
      if (submit) begin
        word_len <= fill_len;
        fill_len <= '0; // Next word starts empty
      end else if (append) begin
        fill_len <= fill_len + word_pkg::word_len_t'(1);
      end
      if (game_end)
        game_over <= 1'b1; // Held until reset
    end
  end

endmodule

// ==== testbench/keypad_stim.txt ====
// test <name> | press <hold sweeps> <release sweeps> <count> <key codes in hex>
// letter <char> | word <letters> <length> | over
test multi_tap
press 6 6 3 84 84 18
letter B
press 6 6 4 42 42 42 18
letter O
test wrap
press 6 6 5 28 28 28 28 18
letter S
press 6 6 6 28 28 28 28 28 18
letter P
press 6 6 5 84 84 84 84 18
letter A
test key_change
press 6 6 3 82 48 18
letter G
press 6 6 5 84 88 84 81 18
letter B
test clear
press 6 6 5 44 44 14 24 18
letter T
test full_word
press 6 6 1 12
word BOSPAGBT 8
test word_submit
press 6 6 8 84 84 84 18 84 18 24 18
letter C
letter A
letter T
press 6 6 1 12
word CAT 3
press 6 6 3 48 18 12
letter G
word G 1
test game_end
press 8 8 1 21
over
press 6 6 2 44 84
over

// ==== testbench/tb_keypad_word.sv ====
`include "keypad_params.svh"

module tb_keypad_word;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int sweep_cycles = 4 * `KEYPAD_SCAN_DIV; // One pass over all columns
  localparam int wait_limit   = 40 * sweep_cycles;    // Cycles before a wait gives up

  logic                  clk;
  logic                  nRst;
  logic [3:0]            rows;
  logic [3:0]            cols;
  word_pkg::letter_t     letter;
  logic                  letter_ready;
  word_pkg::word_t       word;
  word_pkg::word_len_t   word_len;
  logic                  word_valid;
  logic                  game_over;

  keypad_pkg::key_code_t pressed;     // Key held on the model matrix
  word_pkg::letter_t     letter_q[$]; // Letters seen in arrival order
  word_pkg::word_t       word_q[$];
  int                    len_q[$];
  int                    errors   = 0; // Wrong values
  int                    failures = 0; // Timeouts and lost events
  bit                    over_seen = 1'b0;
  string                 test_name = "reset";

  keypad_word_top uut (
    .clk          (clk),
    .nRst         (nRst),
    .rows         (rows),
    .cols         (cols),
    .letter       (letter),
    .letter_ready (letter_ready),
    .word         (word),
    .word_len     (word_len),
    .word_valid   (word_valid),
    .game_over    (game_over)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk; // 40 ns period

  // A key closes its row only while its column is driven
  assign rows = ((cols & pressed[3:0]) != 4'b0000) ? pressed[7:4] : 4'b0000;

  // Record outputs before this edge updates them
  always @(posedge clk) begin
    if (nRst)
      check_value("cols one-hot", 32'd1, 32'($onehot(cols)));
    if (nRst && letter_ready)
      letter_q.push_back(letter);
    if (nRst && word_valid) begin
      word_q.push_back(word);
      len_q.push_back(int'(word_len));
    end
    if (game_over) begin
      over_seen = 1'b1;
    end else if (over_seen) begin
      $display("game_over fell after it was set, in test %s", test_name);
      failures++;
      over_seen = 1'b0; // Report each drop once
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // Hold a key for some sweeps, then leave the pad open
  task automatic press_key(input keypad_pkg::key_code_t code, input int hold_sweeps,
                           input int gap_sweeps);
    @(posedge clk);
    pressed <= code;
    repeat (hold_sweeps * sweep_cycles) @(posedge clk);
    pressed <= '0;
    repeat (gap_sweeps * sweep_cycles) @(posedge clk);
  endtask

  task automatic expect_letter(input string text);
    int n;
    n = 0;
    while ((letter_q.size() == 0) && (n < wait_limit)) begin
      @(posedge clk);
      n++;
    end
    if (letter_q.size() == 0) begin
      $display("Timeout in test %s, letter_ready never came", test_name);
      failures++;
    end else
      check_value("letter", 32'(text.getc(0)), 32'(letter_q.pop_front()));
  endtask

  task automatic expect_word(input string text, input int len);
    word_pkg::word_t w;
    int              n;
    n = 0;
    while ((word_q.size() == 0) && (n < wait_limit)) begin
      @(posedge clk);
      n++;
    end
    if (word_q.size() == 0) begin
      $display("Timeout in test %s, word_valid never came", test_name);
      failures++;
    end else begin
      w = word_q.pop_front();
      check_value("word_len", len, len_q.pop_front());
      for (int i = 0; i < text.len(); i++) // Slots past the length are stale
        check_value($sformatf("word[%0d]", i), 32'(text.getc(i)), 32'(w[i]));
    end
  endtask

  task automatic expect_over();
    int n;
    n = 0;
    while (!game_over && (n < wait_limit)) begin
      @(posedge clk);
      n++;
    end
    if (!game_over) begin
      $display("Timeout in test %s, game_over never went high", test_name);
      failures++;
    end
  endtask

  initial begin
    int         fd;
    int         hold, gap, count, len;
    logic [7:0] code;
    string      cmd, text;
    nRst    = 1'b0;
    pressed = '0;
    repeat (2) @(posedge clk);
    nRst <= 1'b1;
    check_value("cols", 32'h8, 32'(cols)); // Column 0 driven out of reset
    fd = $fopen("testbench/keypad_stim.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file testbench/keypad_stim.txt could not be opened");
      failures++;
    end
    while ((fd != 0) && ($fscanf(fd, "%s", cmd) == 1)) begin
      case (cmd)
        "test":   void'($fscanf(fd, "%s", test_name));
        "press": begin
          void'($fscanf(fd, "%d %d %d", hold, gap, count));
          repeat (count) begin
            void'($fscanf(fd, "%h", code));
            press_key(code, hold, gap);
          end
        end
        "letter": begin
          void'($fscanf(fd, "%s", text));
          expect_letter(text);
        end
        "word": begin
          void'($fscanf(fd, "%s %d", text, len));
          expect_word(text, len);
        end
        "over":   expect_over();
        default:  void'($fgets(text, fd)); // Comment line is skipped
      endcase
    end
    if (fd != 0)
      $fclose(fd);
    if ((letter_q.size() != 0) || (word_q.size() != 0)) begin
      $display("%0d letters and %0d words came that no test asked for",
               letter_q.size(), word_q.size());
      failures++;
    end
    $display("Checks done with %0d value errors and %0d other failures", errors, failures);
    if ((errors == 0) && (failures == 0))
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+common
common/keypad_pkg.sv
common/word_pkg.sv
keypad/keypad_scan.sv
keypad/keypad_fsm.sv
rtl/word_buffer.sv
rtl/keypad_word_top.sv
testbench/tb_keypad_word.sv
